/* isaPkg.sv */
package isaPkg;

    // data and instruction word
    typedef logic [31:0] wordT;

    // register index, x0 to x31
    typedef logic [4:0] regAddrT;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcodeT;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } aluOpT;

    // funct3 codes used by the decoder
    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;
    localparam logic [2:0] FUNCT3_LW  = 3'b010;
    localparam logic [2:0] FUNCT3_SW  = 3'b010;
    localparam logic [2:0] FUNCT3_BEQ = 3'b000;

    // funct7 codes, SUB is the only alternate
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

endpackage

/* pipePkg.sv */
package pipePkg;

    // fetch to decode
    typedef struct packed {
        isaPkg::wordT pc;
        isaPkg::wordT instr;
        logic         valid;
    } ifIdT;

    // decode to execute
    typedef struct packed {
        isaPkg::wordT    pc;
        isaPkg::wordT    rs1Data;
        isaPkg::wordT    rs2Data;
        isaPkg::wordT    imm;
        isaPkg::regAddrT rs1;
        isaPkg::regAddrT rs2;
        isaPkg::regAddrT rd;
        isaPkg::aluOpT   aluOp;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic            branch;
        logic            useImm;
        logic            valid;
    } idExT;

    // execute to memory
    typedef struct packed {
        isaPkg::wordT    aluResult;
        isaPkg::wordT    storeData;
        isaPkg::regAddrT rd;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic            valid;
    } exMemT;

    // memory to writeback
    typedef struct packed {
        isaPkg::wordT    result;
        isaPkg::regAddrT rd;
        logic            regWrite;
        logic            valid;
    } memWbT;

    // operand source picked by the hazard unit
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_WB,
        FWD_MEM
    } fwdSelT;

    // observation streams at the top level
    typedef struct packed {
        isaPkg::regAddrT rd;
        isaPkg::wordT    data;
    } wbEventT;

    typedef struct packed {
        isaPkg::wordT addr;
        isaPkg::wordT data;
    } storeEventT;

endpackage

/* fetchStage.sv */
`timescale 1ns/10ps

module fetchStage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          progWe,
    input  isaPkg::wordT  progAddr,
    input  isaPkg::wordT  progData,
    input  logic          stallF,
    input  logic          stallD,
    input  logic          flushD,
    input  logic          branchTaken,
    input  isaPkg::wordT  branchTarget,
    output pipePkg::ifIdT ifId
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    isaPkg::wordT imem [IMEM_DEPTH];
    isaPkg::wordT pc;
    isaPkg::wordT instr;

    // progAddr is a word index, loaded only while reset is held
    always_ff @(posedge clk) begin
        if (progWe && !rstN) begin
            imem[progAddr[IMEM_AW-1:0]] <= progData;
        end
    end

    assign instr = imem[pc[IMEM_AW+1:2]];

    // a taken branch wins over a load-use stall
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stallF) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || flushD) begin
            ifId.valid <= 1'b0;
        end else if (!stallD) begin
            ifId <= '{pc: pc, instr: instr, valid: 1'b1};
        end
    end

    // the program port must stay quiet once the core runs
    assert property (@(posedge clk) rstN |-> !progWe)
        else $error("program write while the core is running");

endmodule

/* decodeStage.sv */
`timescale 1ns/10ps

module decodeStage (
    input  logic           clk,
    input  logic           rstN,
    input  pipePkg::ifIdT  ifId,
    input  pipePkg::memWbT memWb,
    input  logic           flushE,
    output pipePkg::idExT  idEx
);

    isaPkg::wordT    regs [32];
    isaPkg::opcodeT  opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    isaPkg::wordT    immI;
    isaPkg::wordT    immS;
    isaPkg::wordT    immB;
    logic            rfWe;
    pipePkg::idExT   idExNext;

    assign opcode = isaPkg::opcodeT'(ifId.instr[6:0]);
    assign funct3 = ifId.instr[14:12];
    assign funct7 = ifId.instr[31:25];

    assign immI = {{20{ifId.instr[31]}}, ifId.instr[31:20]};
    assign immS = {{20{ifId.instr[31]}}, ifId.instr[31:25], ifId.instr[11:7]};
    assign immB = {{19{ifId.instr[31]}}, ifId.instr[31], ifId.instr[7],
                   ifId.instr[30:25], ifId.instr[11:8], 1'b0};

    // register file, x0 never written
    assign rfWe = memWb.valid && memWb.regWrite && (memWb.rd != '0);

    always_ff @(posedge clk) begin
        if (rfWe) begin
            regs[memWb.rd] <= memWb.result;
        end
    end

    // same-cycle write is visible to the read
    function automatic isaPkg::wordT readReg(input isaPkg::regAddrT addr);
        if (addr == '0) begin
            return '0;
        end else if (rfWe && memWb.rd == addr) begin
            return memWb.result;
        end
        return regs[addr];
    endfunction

    always_comb begin
        idExNext          = '0;
        idExNext.pc       = ifId.pc;
        idExNext.rs1      = ifId.instr[19:15];
        idExNext.rs2      = ifId.instr[24:20];
        idExNext.rd       = ifId.instr[11:7];
        idExNext.rs1Data  = readReg(ifId.instr[19:15]);
        idExNext.rs2Data  = readReg(ifId.instr[24:20]);
        idExNext.imm      = immI;
        idExNext.aluOp    = isaPkg::ALU_ADD;
        idExNext.valid    = ifId.valid;
        // anything not matched below leaves every control low
        case (opcode)
            isaPkg::OP: begin
                idExNext.regWrite = 1'b1;
                case ({funct7, funct3})
                    {isaPkg::FUNCT7_BASE, isaPkg::FUNCT3_ADD}: idExNext.aluOp = isaPkg::ALU_ADD;
                    {isaPkg::FUNCT7_SUB, isaPkg::FUNCT3_ADD}:  idExNext.aluOp = isaPkg::ALU_SUB;
                    {isaPkg::FUNCT7_BASE, isaPkg::FUNCT3_AND}: idExNext.aluOp = isaPkg::ALU_AND;
                    {isaPkg::FUNCT7_BASE, isaPkg::FUNCT3_OR}:  idExNext.aluOp = isaPkg::ALU_OR;
                    default: idExNext.regWrite = 1'b0;
                endcase
            end
            isaPkg::OP_IMM: begin
                idExNext.regWrite = (funct3 == isaPkg::FUNCT3_ADD);
                idExNext.useImm   = 1'b1;
            end
            isaPkg::LOAD: begin
                idExNext.regWrite = (funct3 == isaPkg::FUNCT3_LW);
                idExNext.memRead  = (funct3 == isaPkg::FUNCT3_LW);
                idExNext.useImm   = 1'b1;
            end
            isaPkg::STORE: begin
                idExNext.memWrite = (funct3 == isaPkg::FUNCT3_SW);
                idExNext.useImm   = 1'b1;
                idExNext.imm      = immS;
            end
            isaPkg::BRANCH: begin
                idExNext.branch = (funct3 == isaPkg::FUNCT3_BEQ);
                idExNext.imm    = immB;
            end
            default: ;
        endcase
        // a bubble carries no side effects
        if (!ifId.valid) begin
            idExNext.regWrite = 1'b0;
            idExNext.memRead  = 1'b0;
            idExNext.memWrite = 1'b0;
            idExNext.branch   = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || flushE) begin
            idEx.valid    <= 1'b0;
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.branch   <= 1'b0;
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

/* executeStage.sv */
`timescale 1ns/10ps

module executeStage (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::idExT    idEx,
    input  pipePkg::exMemT   exMem,
    input  pipePkg::memWbT   memWb,
    input  pipePkg::fwdSelT  fwdA,
    input  pipePkg::fwdSelT  fwdB,
    output pipePkg::exMemT   exMemOut,
    output logic             branchTaken,
    output isaPkg::wordT     branchTarget
);

    isaPkg::wordT opA;
    isaPkg::wordT rs2Val;
    isaPkg::wordT opB;
    isaPkg::wordT aluOut;

    function automatic isaPkg::wordT fwdMux(
        input pipePkg::fwdSelT sel,
        input isaPkg::wordT    regVal,
        input isaPkg::wordT    memVal,
        input isaPkg::wordT    wbVal
    );
        case (sel)
            pipePkg::FWD_MEM: return memVal;
            pipePkg::FWD_WB:  return wbVal;
            default:          return regVal;
        endcase
    endfunction

    assign opA    = fwdMux(fwdA, idEx.rs1Data, exMem.aluResult, memWb.result);
    assign rs2Val = fwdMux(fwdB, idEx.rs2Data, exMem.aluResult, memWb.result);
    assign opB    = idEx.useImm ? idEx.imm : rs2Val;

    always_comb begin
        case (idEx.aluOp)
            isaPkg::ALU_SUB: aluOut = opA - opB;
            isaPkg::ALU_AND: aluOut = opA & opB;
            isaPkg::ALU_OR:  aluOut = opA | opB;
            default:         aluOut = opA + opB;
        endcase
    end

    // BEQ compares the forwarded register values
    assign branchTaken  = idEx.valid && idEx.branch && (opA == rs2Val);
    assign branchTarget = idEx.pc + idEx.imm;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMemOut.valid    <= 1'b0;
            exMemOut.regWrite <= 1'b0;
            exMemOut.memRead  <= 1'b0;
            exMemOut.memWrite <= 1'b0;
        end else begin
            exMemOut.aluResult <= aluOut;
            exMemOut.storeData <= rs2Val;
            exMemOut.rd        <= idEx.rd;
            exMemOut.regWrite  <= idEx.regWrite;
            exMemOut.memRead   <= idEx.memRead;
            exMemOut.memWrite  <= idEx.memWrite;
            exMemOut.valid     <= idEx.valid;
        end
    end

    // memory-stage forwarding only makes sense from a writing instruction
    assert property (@(posedge clk) disable iff (!rstN)
        (fwdA == pipePkg::FWD_MEM) |-> exMem.regWrite)
        else $error("operand A forwarded from a non-writing memory stage");

endmodule

/* memoryStage.sv */
`timescale 1ns/10ps

module memoryStage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                clk,
    input  logic                rstN,
    input  pipePkg::exMemT      exMem,
    output pipePkg::memWbT      memWb,
    output logic                wbValid,
    output pipePkg::wbEventT    wbEvent,
    output logic                storeValid,
    output pipePkg::storeEventT storeEvent
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    isaPkg::wordT           dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]     wordIdx;
    isaPkg::wordT           loadData;

    // byte address in, whole words only
    assign wordIdx  = exMem.aluResult[DMEM_AW+1:2];
    assign loadData = dmem[wordIdx];

    assign storeValid = exMem.valid && exMem.memWrite;
    assign storeEvent = '{addr: exMem.aluResult, data: exMem.storeData};

    always_ff @(posedge clk) begin
        if (storeValid) begin
            dmem[wordIdx] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWb.valid    <= 1'b0;
            memWb.regWrite <= 1'b0;
        end else begin
            memWb.result   <= exMem.memRead ? loadData : exMem.aluResult;
            memWb.rd       <= exMem.rd;
            memWb.regWrite <= exMem.regWrite;
            memWb.valid    <= exMem.valid;
        end
    end

    // writes to x0 are not reported
    assign wbValid = memWb.valid && memWb.regWrite && (memWb.rd != '0);
    assign wbEvent = '{rd: memWb.rd, data: memWb.result};

endmodule

/* hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
    input  isaPkg::regAddrT  rs1D,
    input  isaPkg::regAddrT  rs2D,
    input  isaPkg::regAddrT  rs1E,
    input  isaPkg::regAddrT  rs2E,
    input  isaPkg::regAddrT  rdE,
    input  logic             memReadE,
    input  isaPkg::regAddrT  rdM,
    input  logic             regWriteM,
    input  isaPkg::regAddrT  rdW,
    input  logic             regWriteW,
    input  logic             branchTaken,
    output pipePkg::fwdSelT  fwdA,
    output pipePkg::fwdSelT  fwdB,
    output logic             stallF,
    output logic             stallD,
    output logic             flushD,
    output logic             flushE
);

    logic loadUse;

    // the younger producer in memory wins over writeback
    function automatic pipePkg::fwdSelT pickFwd(input isaPkg::regAddrT rs);
        if (regWriteM && rdM != '0 && rdM == rs) begin
            return pipePkg::FWD_MEM;
        end else if (regWriteW && rdW != '0 && rdW == rs) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_NONE;
    endfunction

    assign fwdA = pickFwd(rs1E);
    assign fwdB = pickFwd(rs2E);

    // load result is not ready for the instruction right behind it
    assign loadUse = memReadE && (rdE != '0) && (rdE == rs1D || rdE == rs2D);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushD = branchTaken;
    assign flushE = branchTaken || loadUse;

endmodule

/* rvCore.sv */
`timescale 1ns/10ps

module rvCore #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                progWe,
    input  isaPkg::wordT        progAddr,
    input  isaPkg::wordT        progData,
    output logic                wbValid,
    output pipePkg::wbEventT    wbEvent,
    output logic                storeValid,
    output pipePkg::storeEventT storeEvent
);

    pipePkg::ifIdT   ifId;
    pipePkg::idExT   idEx;
    pipePkg::exMemT  exMem;
    pipePkg::memWbT  memWb;
    pipePkg::fwdSelT fwdA;
    pipePkg::fwdSelT fwdB;
    logic            stallF;
    logic            stallD;
    logic            flushD;
    logic            flushE;
    logic            branchTaken;
    isaPkg::wordT    branchTarget;

    fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk, .rstN, .progWe, .progAddr, .progData,
        .stallF, .stallD, .flushD, .branchTaken, .branchTarget,
        .ifId
    );

    decodeStage u_decode (
        .clk, .rstN, .ifId, .memWb, .flushE,
        .idEx
    );

    executeStage u_execute (
        .clk, .rstN, .idEx, .exMem, .memWb, .fwdA, .fwdB,
        .exMemOut(exMem), .branchTaken, .branchTarget
    );

    memoryStage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .clk, .rstN, .exMem,
        .memWb, .wbValid, .wbEvent, .storeValid, .storeEvent
    );

    // decode source fields come straight from the IF/ID instruction
    hazardUnit u_hazard (
        .rs1D(ifId.instr[19:15]),
        .rs2D(ifId.instr[24:20]),
        .rs1E(idEx.rs1),
        .rs2E(idEx.rs2),
        .rdE(idEx.rd),
        .memReadE(idEx.memRead),
        .rdM(exMem.rd),
        .regWriteM(exMem.regWrite),
        .rdW(memWb.rd),
        .regWriteW(memWb.regWrite),
        .branchTaken,
        .fwdA, .fwdB, .stallF, .stallD, .flushD, .flushE
    );

endmodule

/* tbRvCore.sv */
`timescale 1ns/10ps

module tbRvCore;

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int PAT_WORDS    = 128;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_PROG     = RESET_CYCLES - 1;
    localparam int DRAIN_CYCLES = 10;

    logic                clk = 1'b0;
    logic                rstN;
    logic                progWe;
    isaPkg::wordT        progAddr;
    isaPkg::wordT        progData;
    logic                wbValid;
    pipePkg::wbEventT    wbEvent;
    logic                storeValid;
    pipePkg::storeEventT storeEvent;

    isaPkg::wordT        patterns [PAT_WORDS];
    isaPkg::wordT        progWords [MAX_PROG];
    pipePkg::wbEventT    expWb [$];
    pipePkg::storeEventT expStore [$];
    int progLen;
    int stimCycle;
    int releaseCycles;
    int valueErrors;
    int eventErrors;
    int patternErrors;
    int missingRecords;

    rvCore #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH)
    ) u_dut (
        .clk, .rstN, .progWe, .progAddr, .progData,
        .wbValid, .wbEvent, .storeValid, .storeEvent
    );

    always #50 clk = ~clk;

    // one program word per cycle while reset is held, then release
    always @(posedge clk) begin
        if (!rstN) begin
            if (stimCycle < progLen) begin
                progWe   <= 1'b1;
                progAddr <= stimCycle;
                progData <= progWords[stimCycle];
            end else begin
                progWe <= 1'b0;
            end
            if (stimCycle == RESET_CYCLES - 1) begin
                rstN   <= 1'b1;
                progWe <= 1'b0;
            end
            stimCycle <= stimCycle + 1;
        end
    end

    task automatic loadPatterns();
        int p;
        int i;
        pipePkg::wbEventT    wbRec;
        pipePkg::storeEventT stRec;
        progLen = patterns[0];
        if (progLen < 1 || progLen > MAX_PROG) begin
            $display("program length %0d in the pattern file is outside 1 to %0d",
                     progLen, MAX_PROG);
            patternErrors++;
            progLen = 0;
        end else begin
            for (i = 0; i < progLen; i++) begin
                progWords[i] = patterns[1 + i];
            end
            p = 1 + progLen;
            // a zero tag ends the record list
            while (p + 2 < PAT_WORDS && patterns[p] != 0) begin
                case (patterns[p])
                    1: begin
                        wbRec.rd   = patterns[p + 1][4:0];
                        wbRec.data = patterns[p + 2];
                        expWb.push_back(wbRec);
                    end
                    2: begin
                        stRec.addr = patterns[p + 1];
                        stRec.data = patterns[p + 2];
                        expStore.push_back(stRec);
                    end
                    default: begin
                        $display("unknown record tag %0h at pattern word %0d", patterns[p], p);
                        patternErrors++;
                    end
                endcase
                p += 3;
            end
        end
        if (expWb.size() + expStore.size() == 0) begin
            $display("the pattern file holds no expected records");
            patternErrors++;
        end
    endtask

    task automatic checkWriteback();
        pipePkg::wbEventT exp;
        if (expWb.size() == 0) begin
            $display("extra writeback to x%0d at %0t with no record left", wbEvent.rd, $time);
            eventErrors++;
        end else begin
            exp = expWb.pop_front();
            if (wbEvent.rd !== exp.rd) begin
                $display("ERROR time=%0t signal=wbEvent.rd expected=%0d actual=%0d",
                         $time, exp.rd, wbEvent.rd);
                valueErrors++;
            end
            if (wbEvent.data !== exp.data) begin
                $display("ERROR time=%0t signal=wbEvent.data expected=%h actual=%h",
                         $time, exp.data, wbEvent.data);
                valueErrors++;
            end
        end
    endtask

    task automatic checkStore();
        pipePkg::storeEventT exp;
        if (expStore.size() == 0) begin
            $display("extra store to address %h at %0t with no record left",
                     storeEvent.addr, $time);
            eventErrors++;
        end else begin
            exp = expStore.pop_front();
            if (storeEvent.addr !== exp.addr) begin
                $display("ERROR time=%0t signal=storeEvent.addr expected=%h actual=%h",
                         $time, exp.addr, storeEvent.addr);
                valueErrors++;
            end
            if (storeEvent.data !== exp.data) begin
                $display("ERROR time=%0t signal=storeEvent.data expected=%h actual=%h",
                         $time, exp.data, storeEvent.data);
                valueErrors++;
            end
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if ((wbValid || storeValid) && (!rstN || releaseCycles < 2)) begin
            $display("an event came out during reset or right after release at %0t", $time);
            eventErrors++;
        end else begin
            if (wbValid) begin
                checkWriteback();
            end
            if (storeValid) begin
                checkStore();
            end
        end
        if (rstN) begin
            releaseCycles++;
        end
    end

    initial begin
        int runCycles;
        int timeoutLimit;
        int i;
        rstN           = 1'b0;
        progWe         = 1'b0;
        progAddr       = '0;
        progData       = '0;
        stimCycle      = 0;
        releaseCycles  = 0;
        valueErrors    = 0;
        eventErrors    = 0;
        patternErrors  = 0;
        missingRecords = 0;
        for (i = 0; i < PAT_WORDS; i++) begin
            patterns[i] = '0;
        end
        $readmemh("rvCorePatterns.txt", patterns);
        loadPatterns();
        timeoutLimit = progLen * 3 + 50;

        while (!rstN) begin
            @(posedge clk);
        end
        runCycles = 0;
        while ((expWb.size() != 0 || expStore.size() != 0) && runCycles < timeoutLimit) begin
            @(posedge clk);
            runCycles++;
        end

        if (expWb.size() + expStore.size() != 0) begin
            missingRecords = expWb.size() + expStore.size();
            $display("timeout after %0d cycles, %0d writeback and %0d store records not seen",
                     runCycles, expWb.size(), expStore.size());
        end else begin
            // the spin loop at the end must stay silent
            repeat (DRAIN_CYCLES) @(posedge clk);
        end

        $display("summary: %0d value errors, %0d event errors, %0d pattern errors, %0d missing",
                 valueErrors, eventErrors, patternErrors, missingRecords);
        if (valueErrors + eventErrors + patternErrors + missingRecords == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rvCore.f */
isaPkg.sv
pipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
rvCore.sv
tbRvCore.sv

/* runSim.sh */
#!/usr/bin/env bash
# compile and run the rvCore testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbRvCore \
    -f rvCore.f \
    -o simRvCore

./obj_dir/simRvCore | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* rvCorePatterns.txt */
// word 0 is the program length, then one instruction word per line
// records: tag (1 writeback, 2 store), rd or byte address, data
0000000f
5a300093 // addi x1, x0, 0x5a3
1e600113 // addi x2, x0, 0x1e6
002081b3 // add  x3, x1, x2
401181b3 // sub  x3, x3, x1
0011e233 // or   x4, x3, x1
07f20013 // addi x0, x4, 0x7f
00208463 // beq  x1, x2, +8
00402423 // sw   x4, 8(x0)
00802283 // lw   x5, 8(x0)
00228333 // add  x6, x5, x2
00218663 // beq  x3, x2, +12
11100493 // addi x9, x0, 0x111
22200513 // addi x10, x0, 0x222
001373b3 // and  x7, x6, x1
00000063 // beq  x0, x0, 0
// expected writebacks and stores in program order
1 01 000005a3
1 02 000001e6
1 03 00000789
1 03 000001e6
1 04 000005e7
2 00000008 000005e7
1 05 000005e7
1 06 000007cd
1 07 00000581
